// File: common/lsu_pkg.sv
package lsu_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int unsigned XLEN  = 32;              // data and address width
  localparam int unsigned BE_W  = XLEN / 8;        // byte lanes per word
  localparam int unsigned OFF_W = $clog2(BE_W);    // byte offset inside a word

  //////////////////////////////
  // access size
  //////////////////////////////

  // encoding follows the execute stage
  // code 3 has no name and decodes as a byte access wherever it shows up
  typedef enum logic [1:0] {
    WORD = 2'b00,
    HALF = 2'b01,
    BYTE = 2'b10
  } data_type_e;

  //////////////////////////////
  // bus controller states
  //////////////////////////////

  // the _MIS states cover the first half of a split access
  // the plain states cover a single access or the second half
  typedef enum logic [2:0] {
    IDLE            = 3'd0, // no request from execute
    WAIT_GNT_MIS    = 3'd1, // first part requested, grant pending
    WAIT_RVALID_MIS = 3'd2, // first part granted, rvalid pending
    WAIT_GNT        = 3'd3, // request out, waiting for grant
    WAIT_RVALID     = 3'd4  // last part granted, waiting for rvalid
  } ls_fsm_e;

  // one transaction in flight at most
  // the bus allows no second grant before the first rvalid
  // so the controller never overlaps two requests

endpackage

// File: hw/lsu_wr_align.sv
`timescale 1ns/1ps

module lsu_wr_align (
  input  logic [lsu_pkg::XLEN-1:0] adder_result_ex_i, // unaligned address from execute
  input  lsu_pkg::data_type_e      data_type_ex_i,    // word, half or byte
  input  logic [lsu_pkg::XLEN-1:0] data_wdata_ex_i,   // store data, lane 0 based
  input  logic                     data_req_ex_i,     // execute wants an access
  input  logic                     misaligned_q_i,    // second part of a split access

  output logic [lsu_pkg::XLEN-1:0] data_addr_o,       // word aligned bus address
  output logic [lsu_pkg::BE_W-1:0] data_be_o,         // byte enables for this part
  output logic [lsu_pkg::XLEN-1:0] data_wdata_o,      // store data moved into its lanes
  output logic                     misaligned_o       // access needs a second transaction
);

  import lsu_pkg::*;

  logic [OFF_W-1:0]  offset;      // byte offset of the access
  logic [2*XLEN-1:0] wdata_dbl;   // doubled store word for the rotation

  assign offset = adder_result_ex_i[OFF_W-1:0];

  //////////////////////////////
  // byte enables
  //////////////////////////////

  always_comb begin
    case (data_type_ex_i)
      WORD: begin
        if (!misaligned_q_i) begin
          data_be_o = {BE_W{1'b1}} << offset;       // lanes k up to 3
        end else begin
          data_be_o = ~({BE_W{1'b1}} << offset);    // lanes 0 up to k-1
        end
      end

      HALF: begin
        if (!misaligned_q_i) begin
          // offset 3 shifts the upper lane out, leaving lane 3 only
          data_be_o = BE_W'(2'b11) << offset;
        end else begin
          data_be_o = BE_W'(1'b1);            // spill byte lands in lane 0
        end
      end

      default: begin                          // byte, code 3 included
        data_be_o = BE_W'(1'b1) << offset;
      end
    endcase
  end

  //////////////////////////////
  // store data rotation
  //////////////////////////////

  // rotate left by the offset in bytes
  // bytes past lane 3 wrap round to lane 0 for the second part of a split store
  assign wdata_dbl    = {data_wdata_ex_i, data_wdata_ex_i} << {offset, 3'b000};
  assign data_wdata_o = wdata_dbl[2*XLEN-1 -: XLEN];

  // bus only sees whole words
  assign data_addr_o = {adder_result_ex_i[XLEN-1:OFF_W], {OFF_W{1'b0}}};

  //////////////////////////////
  // split detection
  //////////////////////////////

  always_comb begin
    misaligned_o = 1'b0;
    // once the second part runs the address is already the next word
    if (data_req_ex_i && !misaligned_q_i) begin
      case (data_type_ex_i)
        WORD:    misaligned_o = (offset != '0);  // any offset crosses a word
        HALF:    misaligned_o = (offset == '1);  // only the last lane spills
        default: misaligned_o = 1'b0;            // a byte always fits
      endcase
    end
  end

endmodule

// File: hw/lsu_fsm.sv
`timescale 1ns/1ps

module lsu_fsm (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // execute side
  input  logic                     data_req_ex_i,     // level, held until data_valid_o
  input  logic                     data_we_ex_i,      // store when high
  input  logic                     misaligned_i,      // comb split flag from write align
  input  logic [lsu_pkg::XLEN-1:0] data_addr_i,       // aligned address on the bus

  // memory side
  input  logic                     data_gnt_i,
  input  logic                     data_rvalid_i,
  input  logic                     data_err_i,        // only valid with rvalid

  output logic                     data_req_o,
  output logic                     lsu_update_addr_o, // pulse on every grant
  output logic                     data_valid_o,      // end of the whole access
  output logic                     data_misaligned_o, // execute must present address + 4
  output logic                     misaligned_q_o,    // second part running
  output logic [lsu_pkg::XLEN-1:0] addr_last_o,       // last granted address, for traps
  output logic                     load_err_o,
  output logic                     store_err_o
);

  import lsu_pkg::*;

  ls_fsm_e             ls_fsm_cs, ls_fsm_ns;
  logic                misaligned_q;
  logic                data_we_q;    // direction of the granted request
  logic [XLEN-1:0]     addr_last_q;
  logic                bus_err;

  //////////////////////////////
  // request controller
  //////////////////////////////

  always_comb begin
    ls_fsm_ns         = ls_fsm_cs;
    data_req_o        = 1'b0;
    lsu_update_addr_o = 1'b0;
    data_valid_o      = 1'b0;
    data_misaligned_o = 1'b0;

    case (ls_fsm_cs)
      IDLE: begin
        if (data_req_ex_i) begin
          data_req_o = 1'b1;           // leaves in the same cycle
          if (data_gnt_i) begin
            lsu_update_addr_o = 1'b1;
            ls_fsm_ns = misaligned_i ? WAIT_RVALID_MIS : WAIT_RVALID;
          end else begin
            ls_fsm_ns = misaligned_i ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;             // hold under back-pressure
        if (data_gnt_i) begin
          lsu_update_addr_o = 1'b1;
          ls_fsm_ns = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        data_misaligned_o = 1'b1;      // execute switches to the next word
        lsu_update_addr_o = data_gnt_i;
        if (data_rvalid_i) begin
          // first part done, second part goes out right away
          data_req_o = 1'b1;
          ls_fsm_ns  = data_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      WAIT_GNT: begin
        // still high when entered from a split access without a grant
        data_misaligned_o = misaligned_q;
        data_req_o        = 1'b1;
        if (data_gnt_i) begin
          lsu_update_addr_o = 1'b1;
          ls_fsm_ns = WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (data_rvalid_i) begin
          data_valid_o = 1'b1;         // same cycle as the last rvalid
          ls_fsm_ns    = IDLE;
        end
      end

      default: ls_fsm_ns = IDLE;
    endcase
  end

  //////////////////////////////
  // errors and last address
  //////////////////////////////

  assign bus_err     = data_err_i & data_rvalid_i;
  assign load_err_o  = bus_err & ~data_we_q;
  assign store_err_o = bus_err &  data_we_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs    <= IDLE;
      misaligned_q <= 1'b0;
      data_we_q    <= 1'b0;
      addr_last_q  <= '0;
    end else begin
      ls_fsm_cs <= ls_fsm_ns;
      if (lsu_update_addr_o) begin
        misaligned_q <= misaligned_i;  // drops again on the second grant
      end
      if (data_gnt_i) begin
        data_we_q <= data_we_ex_i;     // errors belong to the granted request
      end
      // keep the failing address for the trap handler
      if (data_req_o && data_gnt_i && !(load_err_o || store_err_o)) begin
        addr_last_q <= data_addr_i;
      end
    end
  end

  assign misaligned_q_o = misaligned_q;
  assign addr_last_o    = addr_last_q;

endmodule

// File: hw/lsu_rd_align.sv
`timescale 1ns/1ps

module lsu_rd_align (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      data_gnt_i,         // capture strobe for attributes
  input  lsu_pkg::data_type_e       data_type_ex_i,
  input  logic [lsu_pkg::OFF_W-1:0] data_addr_i,        // byte offset of the unaligned address
  input  logic                      data_sign_ext_ex_i,
  input  logic                      data_we_ex_i,

  input  logic                      data_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0]  data_rdata_i,       // raw bus word

  input  logic                      misaligned_i,       // first part of a split in progress
  input  logic                      misaligned_q_i,     // split flag from the last grant

  output logic [lsu_pkg::XLEN-1:0]  data_rdata_ex_o     // aligned and extended load data
);

  import lsu_pkg::*;

  // attributes of the granted transaction
  data_type_e        data_type_q;
  logic [OFF_W-1:0]  offset_q;
  logic              sign_ext_q;
  logic              data_we_q;

  logic [XLEN-1:0]   rdata_q;       // first part of a split, or the last result
  logic [2*XLEN-1:0] rdata_dbl;     // second word over first word, shifted
  logic [XLEN-1:0]   rdata_shift;   // bus word shifted down to lane 0
  logic [15:0]       half_field;
  logic [7:0]        byte_field;
  logic [XLEN-1:0]   rdata_w;
  logic [XLEN-1:0]   rdata_h;
  logic [XLEN-1:0]   rdata_b;
  logic [XLEN-1:0]   rdata_ext;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_type_q <= WORD;
      offset_q    <= '0;
      sign_ext_q  <= 1'b0;
      data_we_q   <= 1'b0;
    end else if (data_gnt_i) begin
      data_type_q <= data_type_ex_i;
      offset_q    <= data_addr_i;
      sign_ext_q  <= data_sign_ext_ex_i;
      data_we_q   <= data_we_ex_i;
    end
  end

  //////////////////////////////
  // field selection
  //////////////////////////////

  assign rdata_dbl   = {data_rdata_i, rdata_q} >> {offset_q, 3'b000};
  assign rdata_shift = data_rdata_i >> {offset_q, 3'b000};

  // a split word takes the upper lanes of the buffered first part
  assign rdata_w = (offset_q == '0) ? data_rdata_i : rdata_dbl[XLEN-1:0];

  // offset 3 half straddles both words
  assign half_field = (offset_q == '1) ? rdata_dbl[15:0] : rdata_shift[15:0];
  assign byte_field = rdata_shift[7:0];

  // sign comes from the top bit of the selected field
  assign rdata_h = {{(XLEN-16){sign_ext_q & half_field[15]}}, half_field};
  assign rdata_b = {{(XLEN-8){sign_ext_q & byte_field[7]}}, byte_field};

  always_comb begin
    case (data_type_q)
      WORD:    rdata_ext = rdata_w;
      HALF:    rdata_ext = rdata_h;
      default: rdata_ext = rdata_b;   // code 3 reads as a byte too
    endcase
  end

  //////////////////////////////
  // read buffer
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (data_rvalid_i && !data_we_q) begin
      if (misaligned_i || misaligned_q_i) begin
        rdata_q <= data_rdata_i;      // raw word, reassembled on the second rvalid
      end else begin
        rdata_q <= rdata_ext;         // hold the result after rvalid goes away
      end
    end
  end

  // live result while rvalid is up, buffered result otherwise
  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;

endmodule

// File: hw/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // execute stage
  input  logic                     data_req_ex_i,      // held until data_valid_o
  input  logic                     data_we_ex_i,
  input  lsu_pkg::data_type_e      data_type_ex_i,
  input  logic                     data_sign_ext_ex_i,
  input  logic [lsu_pkg::XLEN-1:0] data_wdata_ex_i,
  input  logic [lsu_pkg::XLEN-1:0] adder_result_ex_i,  // access address

  output logic [lsu_pkg::XLEN-1:0] data_rdata_ex_o,
  output logic                     data_valid_o,
  output logic                     data_misaligned_o,  // present address + 4 next
  output logic                     lsu_update_addr_o,
  output logic [lsu_pkg::XLEN-1:0] addr_last_o,
  output logic                     load_err_o,
  output logic                     store_err_o,

  // data memory bus
  output logic                     data_req_o,
  input  logic                     data_gnt_i,
  input  logic                     data_rvalid_i,
  input  logic                     data_err_i,
  output logic [lsu_pkg::XLEN-1:0] data_addr_o,
  output logic                     data_we_o,
  output logic [lsu_pkg::BE_W-1:0] data_be_o,
  output logic [lsu_pkg::XLEN-1:0] data_wdata_o,
  input  logic [lsu_pkg::XLEN-1:0] data_rdata_i
);

  import lsu_pkg::*;

  logic misaligned;     // comb split request
  logic misaligned_q;   // second part running

  assign data_we_o = data_we_ex_i; // direction goes out unchanged

  // request side, fully combinational
  lsu_wr_align u_wr_align (
    .adder_result_ex_i ( adder_result_ex_i ),
    .data_type_ex_i    ( data_type_ex_i    ),
    .data_wdata_ex_i   ( data_wdata_ex_i   ),
    .data_req_ex_i     ( data_req_ex_i     ),
    .misaligned_q_i    ( misaligned_q      ),
    .data_addr_o       ( data_addr_o       ),
    .data_be_o         ( data_be_o         ),
    .data_wdata_o      ( data_wdata_o      ),
    .misaligned_o      ( misaligned        )
  );

  lsu_fsm u_fsm (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .data_req_ex_i     ( data_req_ex_i     ),
    .data_we_ex_i      ( data_we_ex_i      ),
    .misaligned_i      ( misaligned        ),
    .data_addr_i       ( data_addr_o       ),
    .data_gnt_i        ( data_gnt_i        ),
    .data_rvalid_i     ( data_rvalid_i     ),
    .data_err_i        ( data_err_i        ),
    .data_req_o        ( data_req_o        ),
    .lsu_update_addr_o ( lsu_update_addr_o ),
    .data_valid_o      ( data_valid_o      ),
    .data_misaligned_o ( data_misaligned_o ),
    .misaligned_q_o    ( misaligned_q      ),
    .addr_last_o       ( addr_last_o       ),
    .load_err_o        ( load_err_o        ),
    .store_err_o       ( store_err_o       )
  );

  // response side takes the unaligned offset, the bus address has it cleared
  lsu_rd_align u_rd_align (
    .clk_i              ( clk_i                          ),
    .rst_ni             ( rst_ni                         ),
    .data_gnt_i         ( data_gnt_i                     ),
    .data_type_ex_i     ( data_type_ex_i                 ),
    .data_addr_i        ( adder_result_ex_i[OFF_W-1:0]   ),
    .data_sign_ext_ex_i ( data_sign_ext_ex_i             ),
    .data_we_ex_i       ( data_we_ex_i                   ),
    .data_rvalid_i      ( data_rvalid_i                  ),
    .data_rdata_i       ( data_rdata_i                   ),
    .misaligned_i       ( data_misaligned_o              ),
    .misaligned_q_i     ( misaligned_q                   ),
    .data_rdata_ex_o    ( data_rdata_ex_o                )
  );

endmodule

// File: verification/tb_lsu_mem.sv
`timescale 1ns/1ps

module tb_lsu_mem (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,     // word aligned
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,   // one cycle after the grant
  output logic        err_o,
  output logic [31:0] rdata_o
);

  localparam int unsigned   DEPTH    = 256;
  localparam logic [31:0]   ERR_BASE = 32'h380;   // error window up to the top
  localparam logic [31:0]   SEED     = 32'd97963;

  logic [31:0] mem [DEPTH];
  logic [31:0] lfsr_q;
  logic [31:0] step_a, step_b;  // two steps, one bit each
  logic [1:0]  delay_q;         // grant delay of the pending request
  logic [1:0]  wait_cnt_q;

  // fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 32'h9E3779B9 * (i + 1);   // every word differs
    end
  end

  assign gnt_o = req_i && (wait_cnt_q == delay_q);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o   <= 1'b0;
      err_o      <= 1'b0;
      rdata_o    <= '0;
      wait_cnt_q <= '0;
      delay_q    <= '0;
      lfsr_q     <= SEED;
    end else begin
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
      if (req_i) begin
        if (gnt_o) begin
          step_a = lfsr_next(lfsr_q);
          step_b = lfsr_next(step_a);
          lfsr_q     <= step_b;
          delay_q    <= {step_a[0], step_b[0]}; // 0 to 3 cycles for the next one
          wait_cnt_q <= '0;
          rvalid_o   <= 1'b1;
          err_o      <= (addr_i >= ERR_BASE);
          rdata_o    <= mem[addr_i[9:2]];
          if (we_i && addr_i < ERR_BASE) begin
            for (int b = 0; b < 4; b++) begin
              if (be_i[b]) mem[addr_i[9:2]][8*b +: 8] <= wdata_i[8*b +: 8];
            end
          end
        end else begin
          wait_cnt_q <= wait_cnt_q + 2'd1;  // back-pressure
        end
      end
    end
  end

endmodule

// File: verification/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

  import lsu_pkg::*;

  localparam time         CLK_PERIOD = 20ns;
  localparam int unsigned N_RANDOM   = 32;
  localparam int unsigned N_TESTS    = 47 + N_RANDOM;  // fixed plus random accesses
  localparam logic [31:0] ERR_BASE   = 32'h380;

  logic        clk_i, rst_ni;
  logic        data_req_ex_i, data_we_ex_i, data_sign_ext_ex_i;
  data_type_e  data_type_ex_i;
  logic [31:0] data_wdata_ex_i, adder_result_ex_i;
  logic [31:0] data_rdata_ex_o, addr_last_o;
  logic        data_valid_o, data_misaligned_o, lsu_update_addr_o, load_err_o, store_err_o;
  logic        data_req_o, data_gnt_i, data_rvalid_i, data_err_i, data_we_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i;
  logic [3:0]  data_be_o;

  // reference state
  logic [7:0]  shadow [1024];   // byte image of the memory
  string       cur_name;
  logic        cur_we, cur_mis, check_load, switched, mis_seen;
  data_type_e  cur_type;
  logic [31:0] exp_rdata, exp_last, rnd_q;
  int unsigned exp_grants, grants;

  lsu_top dut_i (.*);

  tb_lsu_mem mem_i (
    .clk_i, .rst_ni, .req_i(data_req_o), .we_i(data_we_o), .addr_i(data_addr_o),
    .be_i(data_be_o), .wdata_i(data_wdata_o), .gnt_o(data_gnt_i),
    .rvalid_o(data_rvalid_i), .err_o(data_err_i), .rdata_o(data_rdata_i)
  );

  //////////////////////////////
  // failure reporting
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    abort_run($sformatf("Error %s expected %h actual %h", name, exp, act));
  endtask

  // fibonacci LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      rnd_q = {rnd_q[30:0], rnd_q[31] ^ rnd_q[21] ^ rnd_q[1] ^ rnd_q[0]};
      r     = {r[30:0], rnd_q[0]};
    end
    return r;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(N_TESTS * 20 * CLK_PERIOD);
    abort_run("Timeout: the DUT did not finish its accesses in time");
  end

  //////////////////////////////
  // bus and output monitor
  //////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      assert (!(data_req_o | data_valid_o | data_misaligned_o | lsu_update_addr_o |
                load_err_o | store_err_o))
        else abort_run("A control output is high during reset");
      assert (addr_last_o == '0) else value_error("reset_addr_last", '0, addr_last_o);
    end else begin
      if (data_req_o) begin
        assert (data_addr_o[1:0] == 2'b00)
          else value_error({cur_name, "_addr_align"}, '0, 32'(data_addr_o[1:0]));
        if (cur_type == WORD && !cur_mis) begin
          assert (data_be_o == 4'hF) else value_error(cur_name, 32'hF, 32'(data_be_o));
        end
      end
      assert (addr_last_o == exp_last)
        else value_error({cur_name, "_addr_last"}, exp_last, addr_last_o);
      // one update pulse for every grant
      assert (lsu_update_addr_o == data_gnt_i)
        else value_error({cur_name, "_update_addr"}, 32'(data_gnt_i), 32'(lsu_update_addr_o));
      // errors come only with rvalid and match the direction
      assert (load_err_o == (data_rvalid_i && data_err_i && !cur_we))
        else value_error({cur_name, "_load_err"},
                         32'(data_rvalid_i && data_err_i && !cur_we), 32'(load_err_o));
      assert (store_err_o == (data_rvalid_i && data_err_i && cur_we))
        else value_error({cur_name, "_store_err"},
                         32'(data_rvalid_i && data_err_i && cur_we), 32'(store_err_o));
      if (data_misaligned_o) mis_seen = 1'b1;
      if (data_valid_o) begin
        assert (grants == exp_grants) else value_error({cur_name, "_grants"}, exp_grants, grants);
        assert (mis_seen == cur_mis)
          else value_error({cur_name, "_misaligned"}, 32'(cur_mis), 32'(mis_seen));
        if (!cur_we && check_load) begin
          assert (data_rdata_ex_o == exp_rdata)
            else value_error(cur_name, exp_rdata, data_rdata_ex_o);
        end
        grants   = 0;
        mis_seen = 1'b0;
      end
      if (data_req_o && data_gnt_i) begin
        grants++;
        if (!(data_rvalid_i && data_err_i)) exp_last = {adder_result_ex_i[31:2], 2'b00};
        if (cur_mis && !switched) begin
          adder_result_ex_i <= adder_result_ex_i + 32'd4;  // second part
          switched = 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // execute stage driver
  //////////////////////////////

  task automatic run_access(input string name, input logic we, input data_type_e dtype,
                            input logic sext, input logic [31:0] addr, input logic [31:0] wdata);
    int unsigned size;
    logic [31:0] v;
    size = (dtype == WORD) ? 4 : (dtype == HALF) ? 2 : 1;
    cur_name = name;
    cur_we   = we;
    cur_type = dtype;
    switched = 1'b0;
    cur_mis  = (dtype == WORD && addr[1:0] != 2'd0) || (dtype == HALF && addr[1:0] == 2'd3);
    exp_grants = cur_mis ? 2 : 1;
    check_load = 1'b1;
    v = '0;
    for (int i = 0; i < size; i++) begin
      if (addr + i >= ERR_BASE) check_load = 1'b0;  // no data behind an error
      v[8*i +: 8] = shadow[addr + i];
      if (we && addr + i < ERR_BASE) shadow[addr + i] = wdata[8*i +: 8];
    end
    if (sext && size == 2 && v[15]) v[31:16] = '1;
    if (sext && size == 1 && v[7]) v[31:8] = '1;
    exp_rdata = v;
    @(posedge clk_i);
    data_req_ex_i      <= 1'b1;
    data_we_ex_i       <= we;
    data_type_ex_i     <= dtype;
    data_sign_ext_ex_i <= sext;
    adder_result_ex_i  <= addr;
    data_wdata_ex_i    <= wdata;
    do @(posedge clk_i); while (!data_valid_o);
    data_req_ex_i <= 1'b0;
    @(negedge clk_i);
  endtask

  initial begin
    logic [31:0] a;
    logic [1:0]  t;
    logic        we_r, sx_r;
    logic [31:0] wd_r;
    data_req_ex_i = 1'b0;
    data_we_ex_i = 1'b0;
    data_type_ex_i = WORD;
    data_sign_ext_ex_i = 1'b0;
    data_wdata_ex_i = '0;
    adder_result_ex_i = '0;
    rst_ni = 1'b0;
    cur_name = "reset";
    cur_we = 1'b0;
    cur_mis = 1'b0;
    cur_type = WORD;
    mis_seen = 1'b0;
    grants = 0;
    exp_last = '0;
    rnd_q = 32'd97963;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int w = 0; w < 256; w++) begin
      for (int b = 0; b < 4; b++) shadow[4*w + b] = mem_i.mem[w][8*b +: 8];
    end
    @(negedge clk_i);

    // aligned words
    run_access("st_word_0", 1'b1, WORD, 1'b0, 32'h10, 32'hDEADBEEF);
    run_access("st_word_1", 1'b1, WORD, 1'b0, 32'h14, 32'h01234567);
    run_access("ld_word_0", 1'b0, WORD, 1'b0, 32'h10, '0);
    run_access("ld_word_1", 1'b0, WORD, 1'b0, 32'h14, '0);

    // byte and half fields, both extensions
    run_access("st_fields", 1'b1, WORD, 1'b0, 32'h20, 32'h80FF7F01);
    for (int k = 0; k < 4; k++) begin
      run_access($sformatf("ld_byte_u%0d", k), 1'b0, BYTE, 1'b0, 32'h20 + k, '0);
      run_access($sformatf("ld_byte_s%0d", k), 1'b0, BYTE, 1'b1, 32'h20 + k, '0);
      run_access($sformatf("st_byte_%0d", k), 1'b1, BYTE, 1'b0, 32'h24 + k, 32'hA0 + k);
      // the other three lanes must still hold their old bytes
      run_access($sformatf("ld_bytes_back_%0d", k), 1'b0, WORD, 1'b0, 32'h24, '0);
    end
    for (int k = 0; k < 3; k++) begin
      run_access($sformatf("ld_half_u%0d", k), 1'b0, HALF, 1'b0, 32'h20 + k, '0);
      run_access($sformatf("ld_half_s%0d", k), 1'b0, HALF, 1'b1, 32'h20 + k, '0);
    end

    // split accesses
    for (int k = 1; k < 4; k++) begin
      run_access($sformatf("ld_mis_word_%0d", k), 1'b0, WORD, 1'b0, 32'h40 + k, '0);
      run_access($sformatf("st_mis_word_%0d", k), 1'b1, WORD, 1'b0, 32'h50 + 8*k + k,
                 32'hC0DE0000 + k);
      run_access($sformatf("ld_mis_lo_%0d", k), 1'b0, WORD, 1'b0, 32'h50 + 8*k, '0);
      run_access($sformatf("ld_mis_hi_%0d", k), 1'b0, WORD, 1'b0, 32'h54 + 8*k, '0);
    end
    run_access("ld_mis_half", 1'b0, HALF, 1'b1, 32'h23, '0);
    run_access("st_mis_half", 1'b1, HALF, 1'b0, 32'h73, 32'h0000BEEF);
    run_access("ld_mis_half_back", 1'b0, HALF, 1'b0, 32'h73, '0);

    // error window
    run_access("st_err", 1'b1, WORD, 1'b0, 32'h380, 32'h12345678);
    run_access("ld_err", 1'b0, WORD, 1'b0, 32'h384, '0);
    run_access("ld_err_byte", 1'b0, BYTE, 1'b1, 32'h3A1, '0);
    run_access("st_err_split", 1'b1, WORD, 1'b0, 32'h37E, 32'hFACEB00C);
    run_access("ld_err_split_lo", 1'b0, WORD, 1'b0, 32'h37C, '0);

    // random mix
    for (int n = 0; n < N_RANDOM; n++) begin
      t    = 2'(take_bits(2));
      a    = take_bits(10);
      we_r = 1'(take_bits(1));
      sx_r = 1'(take_bits(1));
      wd_r = take_bits(32);
      if (a >= 32'h3F8) a = a - 32'h10;
      run_access($sformatf("rand_%0d", n), we_r, (t == 2'd3) ? WORD : data_type_e'(t),
                 sx_r, a, wd_r);
    end

    $display("Regression passed");
    $finish;
  end

endmodule

// File: tb.f
common/lsu_pkg.sv
hw/lsu_wr_align.sv
hw/lsu_fsm.sv
hw/lsu_rd_align.sv
hw/lsu_top.sv
verification/tb_lsu_mem.sv
verification/tb_lsu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
